// File: src.f
+incdir+source
source/bruPkg.sv
source/fetchAxiMaster.sv
source/branchCond.sv
source/pcPipeline.sv
source/branchFrontEnd.sv
bench/axiImemModel.sv
bench/tbBranchFrontEnd.sv

// File: Makefile
# Tool, options, top module and file list
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
TOP       := tbBranchFrontEnd
FILELIST  := src.f
OBJDIR    := obj_dir
PASSMSG   := No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: bench/tbBranchFrontEnd.sv
`timescale 1ns/10ps
`include "bru_params.svh"

module tbBranchFrontEnd
  import bruPkg::*;
();

  localparam int waitLimit = 40;
  // IMM and RTD words, fields unused by the front end
  localparam word_t immInstr = {6'o54, 26'd0};
  localparam word_t rtdInstr = {6'o55, 5'd15, 5'd3, 16'h0008};

  logic       gclk;
  logic       grst;
  logic       delayEn;
  logic       arvalid;
  word_t      araddr;
  logic [2:0] arprot;
  logic       arready;
  logic       rvalid;
  word_t      rdata;
  logic [1:0] rresp;
  logic       rready;
  fwdSel_t    fwdSel;
  word_t      rResult;
  word_t      rDwbDi;
  word_t      rRegA;
  word_t      xResult;
  pcWord_t    pc;
  pcWord_t    pcLink;
  logic       dSkip;
  logic       xSkip;
  logic [1:0] atomBorder;

  // Expected program image, copied into the memory model
  word_t progMem [0:`BRU_IMEM_DEPTH-1];
  int    errorCount = 0;
  int    timeoutCount = 0;

  branchFrontEnd dut_i (
    .gclk       (gclk),
    .grst       (grst),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .arprot     (arprot),
    .arready    (arready),
    .rvalid     (rvalid),
    .rdata      (rdata),
    .rresp      (rresp),
    .rready     (rready),
    .fwdSel     (fwdSel),
    .rResult    (rResult),
    .rDwbDi     (rDwbDi),
    .rRegA      (rRegA),
    .xResult    (xResult),
    .pc         (pc),
    .pcLink     (pcLink),
    .dSkip      (dSkip),
    .xSkip      (xSkip),
    .atomBorder (atomBorder)
  );

  axiImemModel imem_i (
    .gclk    (gclk),
    .grst    (grst),
    .delayEn (delayEn),
    .arvalid (arvalid),
    .araddr  (araddr),
    .arready (arready),
    .rvalid  (rvalid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rready  (rready)
  );

  initial begin
    gclk = 1'b0;
    forever #50 gclk = ~gclk;
  end

  task automatic checkWord(input pcWord_t got, input pcWord_t exp, input string what);
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic checkFlag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errorCount++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Branch rule table on the forwarded operand
  function automatic logic takenFor(input word_t w, input word_t op);
    logic signed [31:0] v;
    v = op;
    case (w[31:26])
      6'o46, 6'o56: takenFor = 1'b1;
      6'o47, 6'o57: begin
        case (w[23:21])
          3'd0:    takenFor = (v == 0);
          3'd1:    takenFor = (v != 0);
          3'd2:    takenFor = (v < 0);
          3'd3:    takenFor = (v <= 0);
          3'd4:    takenFor = (v > 0);
          3'd5:    takenFor = (v >= 0);
          default: takenFor = 1'b0;
        endcase
      end
      default: takenFor = 1'b0;
    endcase
  endfunction

  // ra[4] for BR, rd[4] for Bcc
  function automatic logic delayBit(input word_t w);
    case (w[31:26])
      6'o46, 6'o56: delayBit = w[20];
      6'o47, 6'o57: delayBit = w[25];
      default:      delayBit = 1'b0;
    endcase
  endfunction

  function automatic logic holdsBorder(input word_t w);
    case (w[31:26])
      6'o54, 6'o55, 6'o46, 6'o47, 6'o56, 6'o57: holdsBorder = 1'b1;
      default: holdsBorder = 1'b0;
    endcase
  endfunction

  function automatic word_t pickOperand(input fwdSel_t s, input word_t a, input word_t res,
                                        input word_t dwb);
    case (s)
      2'd1:    pickOperand = res;
      2'd2:    pickOperand = dwb;
      default: pickOperand = a;
    endcase
  endfunction

  function automatic word_t brWord(input opcode_t opc, input logic withDelay);
    brWord = {opc, 5'd0, withDelay, 4'd0, 16'h0000};
  endfunction

  function automatic word_t bccWord(input opcode_t opc, input logic [2:0] cond,
                                    input logic withDelay);
    bccWord = {opc, withDelay, 1'b0, cond, 5'd0, 16'h0000};
  endfunction

  task automatic fillProgram();
    int i;
    for (i = 0; i < `BRU_IMEM_DEPTH; i++) begin
      // Plain ALU word tagged with its own address
      progMem[i] = {6'o00, 26'(i)};
    end
  endtask

  // Operands stay fixed for a whole run
  task automatic startRun(input fwdSel_t sel, input word_t a, input word_t res,
                          input word_t dwb, input word_t x, input logic delays);
    int i;
    @(posedge gclk);
    grst    <= 1'b1;
    fwdSel  <= sel;
    rRegA   <= a;
    rResult <= res;
    rDwbDi  <= dwb;
    xResult <= x;
    delayEn <= delays;
    for (i = 0; i < `BRU_IMEM_DEPTH; i++) begin
      imem_i.mem[i] = progMem[i];
    end
    repeat (5) @(posedge gclk);
    grst <= 1'b0;
  endtask

  task automatic waitAddr(input pcWord_t expAddr, output logic ok);
    int cycles;
    ok = 1'b0;
    for (cycles = 0; cycles < waitLimit; cycles++) begin
      @(posedge gclk);
      // Held from arvalid until arready
      if (arvalid) begin
        checkWord(araddr[`BRU_DATA_W-1:2], expAddr, "araddr word");
        checkFlag(|araddr[1:0], 1'b0, "araddr alignment");
        checkFlag(|arprot, 1'b0, "arprot");
      end
      if (arvalid && arready) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      timeoutCount++;
      $display("Timeout at %0t: read address was never accepted", $time);
    end
  endtask

  task automatic waitData(output logic ok);
    int cycles;
    ok = 1'b0;
    for (cycles = 0; cycles < waitLimit; cycles++) begin
      @(posedge gclk);
      if (rvalid && rready) begin
        ok = 1'b1;
        break;
      end
    end
    if (!ok) begin
      timeoutCount++;
      $display("Timeout at %0t: no read data beat arrived", $time);
    end
  endtask

  // Fetch sequence, skips, PC stages and atomic marker against the rules
  task automatic runProgram(input int fetches);
    pcWord_t    expFetch;
    pcWord_t    hist[$];
    pcWord_t    expPc;
    pcWord_t    expLink;
    word_t      operand;
    word_t      prevInstr;
    word_t      curInstr;
    logic       taken;
    logic       fSkip;
    logic       fSkipPrev;
    logic       dSkipExp;
    logic       xSkipExp;
    logic       holder;
    logic [1:0] atomExp;
    logic       ok;
    int         k;
    expFetch  = '0;
    prevInstr = '0;
    fSkipPrev = 1'b0;
    xSkipExp  = 1'b0;
    atomExp   = 2'b00;
    operand   = pickOperand(fwdSel, rRegA, rResult, rDwbDi);
    for (k = 0; k < fetches; k++) begin
      waitAddr(expFetch, ok);
      if (!ok) return;
      hist.push_back(expFetch);
      curInstr = progMem[int'(expFetch) % `BRU_IMEM_DEPTH];
      // Previous instruction resolves at this advance
      taken    = takenFor(prevInstr, operand);
      fSkip    = taken && !delayBit(prevInstr);
      dSkipExp = fSkip || fSkipPrev;
      expPc    = (k >= 2) ? hist[k-2] : '0;
      expLink  = (k >= 3) ? hist[k-3] : '0;
      waitData(ok);
      if (!ok) return;
      // State still from the last advance, dSkip already the coming one
      checkFlag(dSkip, dSkipExp, "dSkip");
      checkFlag(xSkip, xSkipExp, "xSkip");
      checkWord(pc, expPc, "pc");
      checkWord(pcLink, expLink, "pcLink");
      checkFlag(atomBorder[0], atomExp[0], "atomBorder[0]");
      checkFlag(atomBorder[1], atomExp[1], "atomBorder[1]");
      xSkipExp  = dSkipExp;
      fSkipPrev = fSkip;
      // A cancelled holder does not keep the border open
      holder    = holdsBorder(curInstr) && !fSkip;
      atomExp   = {atomExp[0], atomExp[0] ^ !holder};
      expFetch  = taken ? xResult[`BRU_DATA_W-1:2] : expFetch + 1'b1;
      prevInstr = curInstr;
    end
  endtask

  task automatic sequentialFetch();
    fillProgram();
    startRun(2'd0, 32'h0000_0001, '0, '0, 32'h0000_0100, 1'b0);
    runProgram(10);
  endtask

  task automatic uncondBranch();
    fillProgram();
    progMem[2] = brWord(6'o56, 1'b0);
    startRun(2'd0, '0, '0, '0, 32'h0000_0080, 1'b0);
    runProgram(7);
    // Delay slot, no cancel
    fillProgram();
    progMem[2] = brWord(6'o46, 1'b1);
    startRun(2'd0, '0, '0, '0, 32'h0000_00a0, 1'b0);
    runProgram(7);
  endtask

  task automatic condBranches();
    word_t   ops [3];
    opcode_t opc;
    int      c;
    int      j;
    ops[0] = 32'h0000_0000;
    ops[1] = 32'hffff_fff0;
    ops[2] = 32'h0000_0011;
    for (c = 0; c < 6; c++) begin
      for (j = 0; j < 3; j++) begin
        opc = c[0] ? 6'o57 : 6'o47;
        fillProgram();
        progMem[1] = bccWord(opc, c[2:0], j[0]);
        // Unselected sources carry misleading values
        startRun(2'd0, ops[j], 32'h0000_0005, 32'h8000_0000, 32'h0000_00c0, 1'b0);
        runProgram(5);
      end
    end
  endtask

  task automatic operandForwarding();
    int s;
    for (s = 0; s < 3; s++) begin
      // Equal to zero, only the selected source is zero
      fillProgram();
      progMem[1] = bccWord(6'o47, 3'd0, 1'b0);
      startRun(fwdSel_t'(s), (s == 0) ? '0 : 32'h0000_0005, (s == 1) ? '0 : 32'h0000_0006,
               (s == 2) ? '0 : 32'h0000_0007, 32'h0000_0040, 1'b0);
      runProgram(5);
      // Negative, only the selected source is negative
      fillProgram();
      progMem[1] = bccWord(6'o57, 3'd2, 1'b0);
      startRun(fwdSel_t'(s), (s == 0) ? 32'h8000_0004 : '0, (s == 1) ? 32'h8000_0004 : '0,
               (s == 2) ? 32'h8000_0004 : '0, 32'h0000_0040, 1'b0);
      runProgram(5);
    end
  endtask

  task automatic linkAndAtom();
    fillProgram();
    progMem[1]  = immInstr;
    progMem[3]  = brWord(6'o56, 1'b1);
    progMem[20] = rtdInstr;
    progMem[22] = immInstr;
    // Not zero with delay, loops back to word 20
    progMem[23] = bccWord(6'o47, 3'd1, 1'b1);
    startRun(2'd0, 32'h0000_0003, '0, '0, 32'h0000_0050, 1'b0);
    runProgram(12);
  endtask

  task automatic backPressure();
    fillProgram();
    progMem[2]  = brWord(6'o56, 1'b0);
    progMem[11] = bccWord(6'o57, 3'd2, 1'b1);
    startRun(2'd1, '0, 32'hffff_ff00, '0, 32'h0000_0028, 1'b1);
    runProgram(14);
  endtask

  initial begin
    grst    = 1'b1;
    delayEn = 1'b0;
    fwdSel  = '0;
    rResult = '0;
    rDwbDi  = '0;
    rRegA   = '0;
    xResult = '0;
    sequentialFetch();
    uncondBranch();
    condBranches();
    operandForwarding();
    linkAndAtom();
    backPressure();
    $display("Summary: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: bench/axiImemModel.sv
`timescale 1ns/10ps
`include "bru_params.svh"

module axiImemModel
  import bruPkg::*;
(
  input  logic       gclk,
  input  logic       grst,
  input  logic       delayEn,
  input  logic       arvalid,
  input  word_t      araddr,
  output logic       arready,
  output logic       rvalid,
  output word_t      rdata,
  output logic [1:0] rresp,
  input  logic       rready
);

  // Program words, written by the testbench
  word_t  mem [0:`BRU_IMEM_DEPTH-1];

  // Delay source for ready and valid
  integer seed = 32'h53c7_43e4;
  int     arWait;
  int     rWait;
  logic   busy;
  int     idx;

  // Addresses past the depth wrap around
  assign idx = araddr[`BRU_DATA_W-1:2] % `BRU_IMEM_DEPTH;

  // Always OKAY
  assign rresp = 2'b00;

  always @(posedge gclk) begin
    if (grst) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
      busy    <= 1'b0;
      arWait  <= 0;
      rWait   <= 0;
    end else begin
      // arready is a one-cycle pulse
      arready <= 1'b0;
      if (arvalid && arready) begin
        busy  <= 1'b1;
        rdata <= mem[idx];
        rWait <= delayEn ? ($random(seed) & 3) : 0;
      end else if (arvalid && !busy) begin
        if (arWait == 0) begin
          arready <= 1'b1;
        end else begin
          arWait <= arWait - 1;
        end
      end
      // Read beat after its own delay
      if (busy && !rvalid) begin
        if (rWait == 0) begin
          rvalid <= 1'b1;
        end else begin
          rWait <= rWait - 1;
        end
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
        busy   <= 1'b0;
        arWait <= delayEn ? ($random(seed) & 3) : 0;
      end
    end
  end

endmodule

// File: source/branchFrontEnd.sv
`timescale 1ns/10ps

module branchFrontEnd
  import bruPkg::*;
(
  input  logic       gclk,
  input  logic       grst,
  // AXI4-Lite read channel
  output logic       arvalid,
  output word_t      araddr,
  output logic [2:0] arprot,
  input  logic       arready,
  input  logic       rvalid,
  input  word_t      rdata,
  input  logic [1:0] rresp,
  output logic       rready,
  // Values from the rest of the pipeline
  input  fwdSel_t    fwdSel,
  input  word_t      rResult,
  input  word_t      rDwbDi,
  input  word_t      rRegA,
  input  word_t      xResult,
  // Front end state
  output pcWord_t    pc,
  output pcWord_t    pcLink,
  output logic       dSkip,
  output logic       xSkip,
  output logic [1:0] atomBorder
);

  logic    advance;
  word_t   instr;
  pcWord_t fetchPc;
  logic    branchTaken;
  logic    delaySlot;

  // Instruction fetch over AXI4-Lite
  fetchAxiMaster fetch_i (
    .gclk    (gclk),
    .grst    (grst),
    .fetchPc (fetchPc),
    .arvalid (arvalid),
    .araddr  (araddr),
    .arprot  (arprot),
    .arready (arready),
    .rvalid  (rvalid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rready  (rready),
    .advance (advance),
    .instr   (instr)
  );

  // Branch decode and resolution
  branchCond cond_i (
    .gclk        (gclk),
    .grst        (grst),
    .advance     (advance),
    .instr       (instr),
    .fwdSel      (fwdSel),
    .rResult     (rResult),
    .rDwbDi      (rDwbDi),
    .rRegA       (rRegA),
    .branchTaken (branchTaken),
    .delaySlot   (delaySlot)
  );

  // PC stages, skips and atomic marker
  pcPipeline pc_i (
    .gclk        (gclk),
    .grst        (grst),
    .advance     (advance),
    .instr       (instr),
    .branchTaken (branchTaken),
    .delaySlot   (delaySlot),
    .xResult     (xResult),
    .fetchPc     (fetchPc),
    .pc          (pc),
    .pcLink      (pcLink),
    .dSkip       (dSkip),
    .xSkip       (xSkip),
    .atomBorder  (atomBorder)
  );

endmodule

// File: source/pcPipeline.sv
`timescale 1ns/10ps
`include "bru_params.svh"

module pcPipeline
  import bruPkg::*;
(
  input  logic       gclk,
  input  logic       grst,
  input  logic       advance,
  input  word_t      instr,
  input  logic       branchTaken,
  input  logic       delaySlot,
  input  word_t      xResult,
  output pcWord_t    fetchPc,
  output pcWord_t    pc,
  output pcWord_t    pcLink,
  output logic       dSkip,
  output logic       xSkip,
  output logic [1:0] atomBorder
);

  // PC stages
  // fetchPcQ next to fetch, ipcQ just fetched, pcQ resolving, linkQ one behind
  pcWord_t    fetchPcQ;
  pcWord_t    ipcQ;
  pcWord_t    pcQ;
  pcWord_t    linkQ;
  pcWord_t    nextFetch;

  // Skip tracking
  logic       fSkip;
  logic       skipQ;
  logic       xSkipQ;

  // Atomic border tracking
  opcode_t    opc;
  logic       holdsBorder;
  logic       fAtom;
  logic [1:0] atomQ;

  // Target on a taken branch, else next word
  assign nextFetch = branchTaken ? xResult[`BRU_DATA_W-1:2] : fetchPcQ + 1'b1;

  // Taken without delay slot cancels the fall-through
  assign fSkip = branchTaken && !delaySlot;
  // Registered copy stretches the cancel over one more advance
  assign dSkip = fSkip || skipQ;

  // IMM, RTD and branches keep the border open unless cancelled
  assign opc = instr[31:26];
  assign holdsBorder = ((opc == opcImm) || (opc == opcRtd) ||
                        (opc == opcBru) || (opc == opcBruI) ||
                        (opc == opcBcc) || (opc == opcBccI)) && !fSkip;
  assign fAtom = !holdsBorder;

  always_ff @(posedge gclk) begin
    if (grst) begin
      fetchPcQ <= '0;
      ipcQ     <= '0;
      pcQ      <= '0;
      linkQ    <= '0;
      skipQ    <= 1'b0;
      xSkipQ   <= 1'b0;
      atomQ    <= 2'b00;
    end else if (advance) begin
      fetchPcQ <= nextFetch;
      ipcQ     <= fetchPcQ;
      pcQ      <= ipcQ;
      linkQ    <= pcQ;
      skipQ    <= fSkip;
      xSkipQ   <= dSkip;
      // Low bit flips on each border-safe instruction
      atomQ    <= {atomQ[0], atomQ[0] ^ fAtom};
    end
  end

  assign fetchPc    = fetchPcQ;
  assign pc         = pcQ;
  assign pcLink     = linkQ;
  assign xSkip      = xSkipQ;
  assign atomBorder = atomQ;

endmodule

// File: source/branchCond.sv
`timescale 1ns/10ps
`include "bru_params.svh"

module branchCond
  import bruPkg::*;
(
  input  logic    gclk,
  input  logic    grst,
  input  logic    advance,
  input  word_t   instr,
  input  fwdSel_t fwdSel,
  input  word_t   rResult,
  input  word_t   rDwbDi,
  input  word_t   rRegA,
  output logic    branchTaken,
  output logic    delaySlot
);

  // Instruction fields
  opcode_t opc;
  regIdx_t rd;
  regIdx_t ra;
  logic    isBru;
  logic    isBcc;

  // Decoded flags, before registering
  logic    careZeroD;
  logic    expectZeroD;
  logic    careSignD;
  logic    expectNegD;
  logic    needBothD;

  // Flags of the branch waiting to resolve
  logic    uncondQ;
  logic    careZeroQ;
  logic    expectZeroQ;
  logic    careSignQ;
  logic    expectNegQ;
  logic    needBothQ;
  logic    delayQ;
  opcode_t lastOpcQ;

  // Operand and compares
  word_t   operand;
  logic    isZero;
  logic    isNeg;
  logic    zeroHit;
  logic    signHit;
  logic    condHit;

  assign opc   = instr[31:26];
  assign rd    = instr[25:21];
  assign ra    = instr[20:16];
  assign isBru = (opc == opcBru) || (opc == opcBruI);
  assign isBcc = (opc == opcBcc) || (opc == opcBccI);

  // Condition code in rd[2:0]
  // Anything that is not a conditional branch leaves every care flag low
  always_comb begin
    careZeroD   = 1'b0;
    expectZeroD = 1'b0;
    careSignD   = 1'b0;
    expectNegD  = 1'b0;
    needBothD   = 1'b0;
    if (isBcc) begin
      case (rd[2:0])
        // Equal to zero
        3'd0: begin
          careZeroD   = 1'b1;
          expectZeroD = 1'b1;
        end
        // Not zero
        3'd1: begin
          careZeroD = 1'b1;
        end
        // Negative
        3'd2: begin
          careSignD  = 1'b1;
          expectNegD = 1'b1;
        end
        // Zero or negative
        3'd3: begin
          careZeroD   = 1'b1;
          expectZeroD = 1'b1;
          careSignD   = 1'b1;
          expectNegD  = 1'b1;
        end
        // Positive and non-zero, both tests must pass
        3'd4: begin
          careZeroD = 1'b1;
          careSignD = 1'b1;
          needBothD = 1'b1;
        end
        // Zero or positive
        3'd5: begin
          careZeroD   = 1'b1;
          expectZeroD = 1'b1;
          careSignD   = 1'b1;
        end
        default: begin
          careZeroD = 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge gclk) begin
    if (grst) begin
      uncondQ     <= 1'b0;
      careZeroQ   <= 1'b0;
      expectZeroQ <= 1'b0;
      careSignQ   <= 1'b0;
      expectNegQ  <= 1'b0;
      needBothQ   <= 1'b0;
      delayQ      <= 1'b0;
      lastOpcQ    <= '0;
    end else if (advance) begin
      uncondQ     <= isBru;
      careZeroQ   <= careZeroD;
      expectZeroQ <= expectZeroD;
      careSignQ   <= careSignD;
      expectNegQ  <= expectNegD;
      needBothQ   <= needBothD;
      // Delay bit sits in ra for BR, in rd for Bcc
      delayQ      <= (isBru && ra[4]) || (isBcc && rd[4]);
      lastOpcQ    <= opc;
    end
  end

  // Three-way forwarding of the compare operand
  always_comb begin
    case (fwdSel)
      2'd1:    operand = rResult;
      2'd2:    operand = rDwbDi;
      default: operand = rRegA;
    endcase
  end

  assign isZero  = (operand == '0);
  assign isNeg   = operand[`BRU_DATA_W-1];
  assign zeroHit = careZeroQ && (isZero == expectZeroQ);
  assign signHit = careSignQ && (isNeg == expectNegQ);
  assign condHit = needBothQ ? (zeroHit && signHit) : (zeroHit || signHit);

  assign branchTaken = uncondQ || condHit;
  assign delaySlot   = delayQ;

  // Taken result only for a branch opcode seen at the last advance
  aTakenIsBranch: assert property (@(posedge gclk) disable iff (grst)
    branchTaken |-> (lastOpcQ == opcBru) || (lastOpcQ == opcBruI) ||
                    (lastOpcQ == opcBcc) || (lastOpcQ == opcBccI))
    else $error("branch taken after a non-branch opcode");

endmodule

// File: source/fetchAxiMaster.sv
`timescale 1ns/10ps

module fetchAxiMaster
  import bruPkg::*;
(
  input  logic        gclk,
  input  logic        grst,
  input  pcWord_t     fetchPc,
  output logic        arvalid,
  output word_t       araddr,
  output logic [2:0]  arprot,
  input  logic        arready,
  input  logic        rvalid,
  input  word_t       rdata,
  input  logic [1:0]  rresp,
  output logic        rready,
  output logic        advance,
  output word_t       instr
);

  fetchState_t state;

  // Byte address from the word PC
  // fetchPc only moves on advance, so it is stable for the whole AR phase
  assign araddr = {fetchPc, 2'b00};

  // Unprivileged, secure, data access
  assign arprot = 3'b000;

  always_ff @(posedge gclk) begin
    if (grst) begin
      state   <= Idle;
      arvalid <= 1'b0;
      rready  <= 1'b0;
      advance <= 1'b0;
      instr   <= '0;
    end else begin
      // Strobe lasts a single cycle
      advance <= 1'b0;
      case (state)
        // Advance cycle or first cycle out of reset
        Idle: begin
          arvalid <= 1'b1;
          state   <= Addr;
        end
        // Hold the request until the memory takes it
        Addr: begin
          if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= Data;
          end
        end
        // Wait for the read beat
        Data: begin
          if (rvalid && rready) begin
            // Error responses still go down the pipe as an instruction
            instr   <= rdata;
            rready  <= 1'b0;
            advance <= 1'b1;
            state   <= Idle;
          end
        end
        default: begin
          state <= Idle;
        end
      endcase
    end
  end

  // Fetch address comes from the PC block and must not move mid request
  aAddrStable: assert property (@(posedge gclk) disable iff (grst)
    arvalid && !arready |=> arvalid && $stable(araddr))
    else $error("araddr or arvalid changed before acceptance");

  // One pipeline step per completed read
  aAdvancePulse: assert property (@(posedge gclk) disable iff (grst)
    advance |=> !advance)
    else $error("advance high on consecutive cycles");

  // Response code must be driven with the beat
  aRespKnown: assert property (@(posedge gclk) disable iff (grst)
    rvalid |-> !$isunknown(rresp))
    else $error("rresp unknown during rvalid");

endmodule

// File: source/bruPkg.sv
`include "bru_params.svh"

package bruPkg;

  // Data and instruction word
  typedef logic [`BRU_DATA_W-1:0] word_t;
  // Word address, byte address without the low two bits
  typedef logic [`BRU_PC_W-1:0] pcWord_t;
  // Major opcode and register fields
  typedef logic [5:0] opcode_t;
  typedef logic [4:0] regIdx_t;
  // Operand source: 0 regA, 1 ALU result, 2 data read
  typedef logic [1:0] fwdSel_t;

  // Fetch master states
  typedef enum logic [1:0] {Idle, Addr, Data} fetchState_t;

  // Opcodes of interest to the front end
  localparam opcode_t opcBru  = 6'o46;
  localparam opcode_t opcBcc  = 6'o47;
  localparam opcode_t opcImm  = 6'o54;
  localparam opcode_t opcRtd  = 6'o55;
  localparam opcode_t opcBruI = 6'o56;
  localparam opcode_t opcBccI = 6'o57;

endpackage

// File: source/bru_params.svh
`ifndef BRU_PARAMS_SVH
`define BRU_PARAMS_SVH

// Data path and instruction word width
`define BRU_DATA_W 32

// Word address width
// Byte address bits 31 down to 2
`define BRU_PC_W 30

// Instruction memory depth in words
`define BRU_IMEM_DEPTH 64

`endif
